// ==== design/apb_if.sv ====
// APB bundle between the top-level pins and the register block
`timescale 1ns/100ps

interface apb_if;
  import e300_glue_pkg::*;

  addr_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  data_t pwdata;
  data_t prdata;
  logic  pready;
  logic  pslverr;

  modport requester (
    output paddr, psel, penable, pwrite, pwdata,
    input  prdata, pready, pslverr
  );

  modport completer (
    input  paddr, psel, penable, pwrite, pwdata,
    output prdata, pready, pslverr
  );

endinterface

// ==== design/board_event_if.sv ====
// synchronised board events towards the register block
`timescale 1ns/100ps

interface board_event_if;
  import e300_glue_pkg::*;

  // single-cycle pulses
  logic        btn_press;
  logic        btn_release;
  logic        pps_tick;
  ref_status_t ref_status;

  modport src (output btn_press, btn_release, pps_tick, ref_status);
  modport dst (input btn_press, btn_release, pps_tick, ref_status);

endinterface

// ==== design/board_events.sv ====
// board event sensing
// on/off button edges, pps and reference status brought into bus_clk
`timescale 1ns/100ps

module board_events #(
  parameter int sync_stages = 2
) (
  input  logic                       bus_clk,
  input  logic                       bus_rst,
  input  logic                       onswitch_db,
  input  logic                       lpps,
  input  e300_glue_pkg::ref_status_t ref_status_raw,
  board_event_if.src                 ev
);
  import e300_glue_pkg::*;

  localparam int sync_w = ref_status_w + 1;

  logic [1:0]                         onswitch_hist;
  logic [sync_stages-1:0][sync_w-1:0] sync_q;
  logic                               pps_sync;
  logic                               pps_last;

  // -----------------------------------------------
  // button, active low, idles high
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      onswitch_hist <= 2'b11;
    end else begin
      onswitch_hist <= {onswitch_hist[0], onswitch_db};
    end
  end

  // low after two high samples, and the mirror case
  assign ev.btn_press   = !onswitch_db && onswitch_hist[0] && onswitch_hist[1];
  assign ev.btn_release = onswitch_db && !onswitch_hist[0] && !onswitch_hist[1];

  // -----------------------------------------------
  // lpps and status share one synchroniser chain
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      sync_q   <= '0;
      pps_last <= 1'b0;
    end else begin
      sync_q   <= {sync_q[sync_stages-2:0], {lpps, ref_status_raw}};
      pps_last <= pps_sync;
    end
  end

  assign pps_sync      = sync_q[sync_stages-1][sync_w-1];
  assign ev.pps_tick   = pps_sync && !pps_last;
  assign ev.ref_status = sync_q[sync_stages-1][ref_status_w-1:0];

  // button edges are exclusive and never repeat on the next cycle
  a_btn_exclusive: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (ev.btn_press || ev.btn_release) |-> !(ev.btn_press && ev.btn_release)
      ##1 !(ev.btn_press || ev.btn_release));

endmodule

// ==== design/e300_glue_pkg.sv ====
// e300 glue package
// widths, register map and field types shared by the bus-clock glue logic

package e300_glue_pkg;

  // -----------------------------------------------
  // field widths
  localparam int addr_w          = 8;
  localparam int data_w          = 32;
  localparam int fe_ctrl_w       = 9;
  localparam int tx_bandsel_w    = 3;
  localparam int rx_bandsel_a_w  = 6;
  localparam int rx_bandsel_bc_w = 4;
  localparam int pps_sel_w       = 2;
  localparam int ref_status_w    = 4;
  localparam int irq_w           = 3;

  typedef logic [addr_w-1:0]          addr_t;
  typedef logic [data_w-1:0]          data_t;
  // tx en a/b, antenna selects, then the three leds
  typedef logic [fe_ctrl_w-1:0]       fe_ctrl_t;
  typedef logic [tx_bandsel_w-1:0]    tx_bandsel_t;
  typedef logic [rx_bandsel_a_w-1:0]  rx_bandsel_a_t;
  typedef logic [rx_bandsel_bc_w-1:0] rx_bandsel_bc_t;
  typedef logic [pps_sel_w-1:0]       pps_sel_t;
  // ref locked, is_pps, is_10meg, pll locked
  typedef logic [ref_status_w-1:0]    ref_status_t;
  typedef logic [irq_w-1:0]           irq_vec_t;

  // irq bit positions
  localparam int irq_press   = 0;
  localparam int irq_release = 1;
  localparam int irq_pps     = 2;

  // -----------------------------------------------
  // register map, byte offsets
  localparam addr_t reg_chan0      = 8'h00;
  localparam addr_t reg_chan1      = 8'h04;
  localparam addr_t reg_bandsel    = 8'h08;
  localparam addr_t reg_misc       = 8'h0C;
  localparam addr_t reg_status     = 8'h10;
  localparam addr_t reg_irq_status = 8'h14;
  localparam addr_t reg_irq_mask   = 8'h18;

  // bandsel field positions
  localparam int bandsel_rx_a_lsb = 3;
  localparam int bandsel_rx_b_lsb = 9;
  localparam int bandsel_rx_c_lsb = 13;

  typedef enum logic {idle, access} apb_state_t;

endpackage

// ==== design/e300_glue_top.sv ====
// e300 bus-clock glue
// APB register block plus button, pps and reference status sensing
`timescale 1ns/100ps

module e300_glue_top #(
  parameter int sync_stages = 2
) (
  input  logic                          bus_clk,
  input  logic                          bus_rst,
  // APB completer
  input  e300_glue_pkg::addr_t          paddr,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  e300_glue_pkg::data_t          pwdata,
  output e300_glue_pkg::data_t          prdata,
  output logic                          pready,
  output logic                          pslverr,
  // board inputs, onswitch_db is active low
  input  logic                          onswitch_db,
  input  logic                          lpps,
  input  e300_glue_pkg::ref_status_t    ref_status_raw,
  // front end and band selects
  output e300_glue_pkg::fe_ctrl_t       fe_ctrl0,
  output e300_glue_pkg::fe_ctrl_t       fe_ctrl1,
  output e300_glue_pkg::tx_bandsel_t    tx_bandsel,
  output e300_glue_pkg::rx_bandsel_a_t  rx_bandsel_a,
  output e300_glue_pkg::rx_bandsel_bc_t rx_bandsel_b,
  output e300_glue_pkg::rx_bandsel_bc_t rx_bandsel_c,
  output e300_glue_pkg::pps_sel_t       pps_select,
  output logic                          irq
);

  apb_if         u_apb ();
  board_event_if u_ev ();

  // requester side comes straight from the pins
  assign u_apb.paddr   = paddr;
  assign u_apb.psel    = psel;
  assign u_apb.penable = penable;
  assign u_apb.pwrite  = pwrite;
  assign u_apb.pwdata  = pwdata;
  assign prdata        = u_apb.prdata;
  assign pready        = u_apb.pready;
  assign pslverr       = u_apb.pslverr;

  board_events #(
    .sync_stages (sync_stages)
  ) u_events (
    .bus_clk        (bus_clk),
    .bus_rst        (bus_rst),
    .onswitch_db    (onswitch_db),
    .lpps           (lpps),
    .ref_status_raw (ref_status_raw),
    .ev             (u_ev.src)
  );

  glue_regs u_regs (
    .bus_clk      (bus_clk),
    .bus_rst      (bus_rst),
    .bus          (u_apb.completer),
    .ev           (u_ev.dst),
    .fe_ctrl0     (fe_ctrl0),
    .fe_ctrl1     (fe_ctrl1),
    .tx_bandsel   (tx_bandsel),
    .rx_bandsel_a (rx_bandsel_a),
    .rx_bandsel_b (rx_bandsel_b),
    .rx_bandsel_c (rx_bandsel_c),
    .pps_select   (pps_select),
    .irq          (irq)
  );

endmodule

// ==== design/glue_regs.sv ====
// glue register block
// APB completer holding front-end control, band selects and sticky irqs
`timescale 1ns/100ps

module glue_regs (
  input  logic                          bus_clk,
  input  logic                          bus_rst,
  apb_if.completer                      bus,
  board_event_if.dst                    ev,
  output e300_glue_pkg::fe_ctrl_t       fe_ctrl0,
  output e300_glue_pkg::fe_ctrl_t       fe_ctrl1,
  output e300_glue_pkg::tx_bandsel_t    tx_bandsel,
  output e300_glue_pkg::rx_bandsel_a_t  rx_bandsel_a,
  output e300_glue_pkg::rx_bandsel_bc_t rx_bandsel_b,
  output e300_glue_pkg::rx_bandsel_bc_t rx_bandsel_c,
  output e300_glue_pkg::pps_sel_t       pps_select,
  output logic                          irq
);
  import e300_glue_pkg::*;

  apb_state_t state;
  logic       acc_phase;
  logic       addr_hit;
  logic       wr_en;
  data_t      rd_data;
  irq_vec_t   irq_status;
  irq_vec_t   irq_mask;
  irq_vec_t   irq_events;
  irq_vec_t   irq_clr;

  // -----------------------------------------------
  // phase tracking, setup always leads into access
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state <= idle;
    end else begin
      case (state)
        idle: begin
          if (bus.psel && !bus.penable) begin
            state <= access;
          end
        end
        access: begin
          state <= idle;
        end
      endcase
    end
  end

  assign acc_phase = (state == access) && bus.psel && bus.penable;
  assign wr_en     = acc_phase && bus.pwrite && addr_hit;

  // -----------------------------------------------
  // read mux and address decode
  always_comb begin
    rd_data  = '0;
    addr_hit = 1'b1;
    case (bus.paddr)
      reg_chan0:      rd_data = data_t'(fe_ctrl0);
      reg_chan1:      rd_data = data_t'(fe_ctrl1);
      reg_bandsel:    rd_data = data_t'({rx_bandsel_c, rx_bandsel_b, rx_bandsel_a, tx_bandsel});
      reg_misc:       rd_data = data_t'(pps_select);
      reg_status:     rd_data = data_t'(ev.ref_status);
      reg_irq_status: rd_data = data_t'(irq_status);
      reg_irq_mask:   rd_data = data_t'(irq_mask);
      default:        addr_hit = 1'b0;
    endcase
  end

  // no wait states
  assign bus.pready  = 1'b1;
  assign bus.prdata  = rd_data;
  assign bus.pslverr = acc_phase && !addr_hit;

  // control registers, status is read only
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      fe_ctrl0     <= '0;
      fe_ctrl1     <= '0;
      tx_bandsel   <= '0;
      rx_bandsel_a <= '0;
      rx_bandsel_b <= '0;
      rx_bandsel_c <= '0;
      pps_select   <= '0;
      irq_mask     <= '0;
    end else if (wr_en) begin
      case (bus.paddr)
        reg_chan0: fe_ctrl0 <= bus.pwdata[fe_ctrl_w-1:0];
        reg_chan1: fe_ctrl1 <= bus.pwdata[fe_ctrl_w-1:0];
        reg_bandsel: begin
          tx_bandsel   <= bus.pwdata[tx_bandsel_w-1:0];
          rx_bandsel_a <= bus.pwdata[bandsel_rx_a_lsb +: rx_bandsel_a_w];
          rx_bandsel_b <= bus.pwdata[bandsel_rx_b_lsb +: rx_bandsel_bc_w];
          rx_bandsel_c <= bus.pwdata[bandsel_rx_c_lsb +: rx_bandsel_bc_w];
        end
        reg_misc:     pps_select <= bus.pwdata[pps_sel_w-1:0];
        reg_irq_mask: irq_mask   <= bus.pwdata[irq_w-1:0];
        default:      ;
      endcase
    end
  end

  // -----------------------------------------------
  // sticky irq status, an event beats a clear
  always_comb begin
    irq_events              = '0;
    irq_events[irq_press]   = ev.btn_press;
    irq_events[irq_release] = ev.btn_release;
    irq_events[irq_pps]     = ev.pps_tick;
  end

  assign irq_clr = (wr_en && bus.paddr == reg_irq_status) ? bus.pwdata[irq_w-1:0] : '0;

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      irq_status <= '0;
    end else begin
      irq_status <= (irq_status & ~irq_clr) | irq_events;
    end
  end

  assign irq = |(irq_status & irq_mask);

  a_penable_needs_psel: assert property (@(posedge bus_clk) disable iff (bus_rst)
    bus.penable |-> bus.psel);

  // setup goes to access with the same address
  a_addr_stable: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (bus.psel && !bus.penable) |=> (bus.psel && bus.penable && $stable(bus.paddr)));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the e300 glue testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --timing --assert -f sim.f --top-module e300_glue_tb 2>&1 \
  && ./obj_dir/Ve300_glue_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation passed" && exit 0 || exit 1

// ==== sim.f ====
design/e300_glue_pkg.sv
design/apb_if.sv
design/board_event_if.sv
design/board_events.sv
design/glue_regs.sv
design/e300_glue_top.sv
tests/e300_glue_tb.sv

// ==== tests/e300_glue_stimulus.txt ====
// op a b c d e | 1 wr addr data, 2 rd addr data err, 3 poll addr data, 4 button, 5 lpps
// 6 ref status, 7 fe chan value, 8 band tx rx_a rx_b rx_c pps, 9 irq vec level, a irq wait, f end
8 0 0 0 0 0
7 0 0 0 0 0
7 1 0 0 0 0
9 0 0 0 0 0
2 00 0 0 0 0
2 08 0 0 0 0
2 10 0 0 0 0
2 18 0 0 0 0
1 00 fffffeab 0 0 0
1 04 0aa 0 0 0
1 08 d355 0 0 0
1 0c 3 0 0 0
7 0 0ab 0 0 0
7 1 0aa 0 0 0
8 5 2a 9 6 3
2 00 0ab 0 0 0
2 04 0aa 0 0 0
2 08 d355 0 0 0
2 0c 3 0 0 0
2 1c 0 1 0 0
1 20 ffffffff 0 0 0
2 00 0ab 0 0 0
1 10 f 0 0 0
2 10 0 0 0 0
4 0 0 0 0 0
3 14 1 0 0 0
9 1 0 0 0 0
4 1 0 0 0 0
3 14 3 0 0 0
9 3 0 0 0 0
1 18 3 0 0 0
a 1 0 0 0 0
9 3 1 0 0 0
1 14 1 0 0 0
9 2 1 0 0 0
1 14 2 0 0 0
9 0 0 0 0 0
1 18 7 0 0 0
5 1 0 0 0 0
a 1 0 0 0 0
9 4 1 0 0 0
5 0 0 0 0 0
1 14 4 0 0 0
9 0 0 0 0 0
6 a 0 0 0 0
3 10 a 0 0 0
f 0 0 0 0 0

// ==== tests/e300_glue_tb.sv ====
// e300 glue testbench
// replays command records from the stimulus file over APB and the board pins
`timescale 1ns/100ps

module e300_glue_tb;
  import e300_glue_pkg::*;

  localparam int rec_w      = 6;
  localparam int max_recs   = 64;
  localparam int wait_limit = 40;

  logic           bus_clk;
  logic           bus_rst;
  addr_t          paddr;
  logic           psel;
  logic           penable;
  logic           pwrite;
  data_t          pwdata;
  data_t          prdata;
  logic           pready;
  logic           pslverr;
  logic           onswitch_db;
  logic           lpps;
  ref_status_t    ref_status_raw;
  fe_ctrl_t       fe_ctrl0;
  fe_ctrl_t       fe_ctrl1;
  tx_bandsel_t    tx_bandsel;
  rx_bandsel_a_t  rx_bandsel_a;
  rx_bandsel_bc_t rx_bandsel_b;
  rx_bandsel_bc_t rx_bandsel_c;
  pps_sel_t       pps_select;
  logic           irq;

  data_t stim [rec_w*max_recs];
  data_t rd_val;
  logic  rd_err;

  e300_glue_top #(.sync_stages(2)) u_dut (.*);

  initial begin
    bus_clk = 1'b0;
    forever #2 bus_clk = ~bus_clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  // -----------------------------------------------
  // compare tasks
  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_fe(input logic ch, input fe_ctrl_t got, input fe_ctrl_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("ERR %0t ns: fe_ctrl%0d is %h, expected %h", $time, ch, got, exp));
    end
  endtask

  task automatic check_irq(input irq_vec_t got, input irq_vec_t exp,
                           input logic got_lvl, input logic exp_lvl);
    if (got !== exp || got_lvl !== exp_lvl) begin
      stop_on_error($sformatf("ERR %0t ns: irq status %b line %b, expected %b line %b",
                              $time, got, got_lvl, exp, exp_lvl));
    end
  endtask

  task automatic check_bandsel(input tx_bandsel_t tx, input rx_bandsel_a_t rx_a,
                               input rx_bandsel_bc_t rx_b, input rx_bandsel_bc_t rx_c,
                               input pps_sel_t pps);
    if ({tx_bandsel, rx_bandsel_a, rx_bandsel_b, rx_bandsel_c, pps_select} !==
        {tx, rx_a, rx_b, rx_c, pps}) begin
      stop_on_error($sformatf("ERR %0t ns: selects %h %h %h %h %h, expected %h %h %h %h %h",
                              $time, tx_bandsel, rx_bandsel_a, rx_bandsel_b, rx_bandsel_c,
                              pps_select, tx, rx_a, rx_b, rx_c, pps));
    end
  endtask

  // -----------------------------------------------
  // APB transfer, entered and left on a falling edge
  task automatic apb_xfer(input logic wr, input addr_t addr, input data_t wdata);
    int cycles;
    cycles  = 0;
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge bus_clk);
    penable = 1'b1;
    #1;
    while (pready !== 1'b1) begin
      @(negedge bus_clk);
      #1;
      cycles++;
      if (cycles > wait_limit) begin
        stop_on_error("the DUT never raised pready");
      end
    end
    rd_val = prdata;
    rd_err = pslverr;
    @(negedge bus_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic poll_reg(input addr_t addr, input data_t exp);
    int tries;
    tries = 0;
    apb_xfer(1'b0, addr, '0);
    while (rd_val !== exp) begin
      tries++;
      if (tries > wait_limit) begin
        stop_on_error($sformatf("register %h never reached %h", addr, exp));
      end
      apb_xfer(1'b0, addr, '0);
    end
  endtask

  task automatic wait_irq(input logic level);
    int cycles;
    cycles = 0;
    while (irq !== level) begin
      @(negedge bus_clk);
      cycles++;
      if (cycles > wait_limit) begin
        stop_on_error($sformatf("irq never went to %b", level));
      end
    end
  endtask

  initial begin
    int    rec;
    data_t op;
    data_t arg [5];
    $timeformat(-9, 1, "", 0);
    void'($urandom(32'h947d_a83e));
    bus_rst        = 1'b1;
    paddr          = '0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = '0;
    onswitch_db    = 1'b1;
    lpps           = 1'b0;
    ref_status_raw = '0;
    $readmemh("tests/e300_glue_stimulus.txt", stim);
    repeat (2) @(posedge bus_clk);
    @(negedge bus_clk);
    bus_rst = 1'b0;

    for (rec = 0; rec < max_recs; rec++) begin
      op = stim[rec*rec_w];
      if (op == 32'hf) begin
        break;
      end
      for (int i = 0; i < 5; i++) begin
        arg[i] = stim[rec*rec_w + i + 1];
      end
      case (op)
        32'h1: apb_xfer(1'b1, addr_t'(arg[0]), arg[1]);
        32'h2: begin
          apb_xfer(1'b0, addr_t'(arg[0]), '0);
          check_data($sformatf("register %h", arg[0][7:0]), rd_val, arg[1]);
          check_data("pslverr", data_t'(rd_err), arg[2]);
        end
        32'h3: poll_reg(addr_t'(arg[0]), arg[1]);
        32'h4: onswitch_db = arg[0][0];
        32'h5: lpps = arg[0][0];
        32'h6: ref_status_raw = ref_status_t'(arg[0]);
        32'h7: check_fe(arg[0][0], arg[0][0] ? fe_ctrl1 : fe_ctrl0, fe_ctrl_t'(arg[1]));
        32'h8: check_bandsel(tx_bandsel_t'(arg[0]), rx_bandsel_a_t'(arg[1]),
                             rx_bandsel_bc_t'(arg[2]), rx_bandsel_bc_t'(arg[3]),
                             pps_sel_t'(arg[4]));
        32'h9: begin
          apb_xfer(1'b0, reg_irq_status, '0);
          check_irq(irq_vec_t'(rd_val), irq_vec_t'(arg[0]), irq, arg[1][0]);
        end
        32'ha: wait_irq(arg[0][0]);
        default: stop_on_error($sformatf("unknown command %h at record %0d", op, rec));
      endcase
      // idle gap between commands
      repeat ($urandom_range(3, 0)) @(negedge bus_clk);
    end

    $display("Simulation passed");
    $finish;
  end

endmodule
